// ==== Bender.yml ====
package:
  name: master_external

sources:
  - files:
      - source/masterPkg.sv
      - source/arbRequester.sv
      - source/frameTransmitter.sv
      - source/frameReceiver.sv
      - source/masterSequencer.sv
      - source/masterExternal.sv
  - target: test
    files:
      - verification/tbClock.sv
      - verification/masterExternal_chk.sv
      - verification/masterTb.sv

// ==== source/arbRequester.sv ====
module arbRequester
    import masterPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  xferReqT req,
    input  logic    arbCont,
    input  logic    releaseBus,  // end of the data phase
    output logic    arbSend,
    output logic    grant,
    output logic    busFree,
    output logic    releaseCtl
);

    arbStateE             state;
    logic [arbReqLen-1:0] reqShift;
    logic [3:0]           cnt;
    logic [1:0]           arbSync;   // last two samples of arbCont
    logic                 pending;   // go seen while the bus was busy

    // grant sampler, only live while waiting for the arbiter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            arbSync <= 2'b00;
        end else if (state != arbWaitGrant) begin
            arbSync <= 2'b00;
        end else begin
            arbSync <= {arbSync[0], arbCont};
        end
    end

    always_ff @(posedge clk) begin
        if (state == arbIdle) begin
            reqShift <= {framePrefix, slaveId};
        end else if (state == arbShift) begin
            reqShift <= reqShift << 1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= arbIdle;
            cnt        <= '0;
            pending    <= 1'b0;
            arbSend    <= 1'b0;
            grant      <= 1'b0;
            busFree    <= 1'b0;
            releaseCtl <= 1'b0;
        end else begin
            grant      <= 1'b0;
            busFree    <= 1'b0;
            releaseCtl <= 1'b0;
            case (state)
                arbIdle: begin
                    arbSend <= 1'b0;
                    if ((req.go || pending) && !arbCont) begin
                        cnt     <= '0;
                        pending <= 1'b0;
                        state   <= arbShift;
                    end else if (req.go) begin
                        pending <= 1'b1;   // line busy, try again later
                    end
                end
                arbShift: begin
                    arbSend <= reqShift[arbReqLen-1];   // msb first
                    cnt     <= cnt + 1'b1;
                    if (cnt == arbReqLen - 1) begin
                        state <= arbWaitGrant;
                    end
                end
                arbWaitGrant: begin
                    arbSend <= 1'b0;
                    if (arbSync == 2'b11) begin
                        arbSend <= 1'b1;   // first ack bit
                        cnt     <= '0;
                        state   <= arbAck;
                    end
                end
                arbAck: begin
                    arbSend <= (cnt == 4'd1);   // 1 0 1, then quiet
                    cnt     <= cnt + 1'b1;
                    if (cnt == 2 + grantWait) begin
                        grant <= 1'b1;
                        state <= arbOwn;
                    end
                end
                arbOwn: begin
                    if (releaseBus) begin
                        releaseCtl <= 1'b1;   // control high, arbSend low
                        cnt        <= '0;
                        state      <= arbRelease;
                    end
                end
                arbRelease: begin
                    cnt <= cnt + 1'b1;
                    if (cnt < 4'd2) begin
                        arbSend <= 1'b1;
                    end else begin
                        arbSend <= 1'b0;
                        busFree <= 1'b1;
                        state   <= arbIdle;
                    end
                end
                default: state <= arbIdle;
            endcase
        end
    end

endmodule

// ==== source/frameReceiver.sv ====
module frameReceiver
    import masterPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic rxEnable,
    input  logic rD,
    input  logic ready,
    output logic rxDone,
    output logic ackOk,
    output dataT payload
);

    readFrameT                         frame;
    logic [$clog2(2*dataWidth)-1:0]    bitCnt;
    logic                              enLatch;  // read window open
    logic                              take;

    // slave paces the read with ready
    assign take = (rxEnable || enLatch) && ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            enLatch <= 1'b0;
            bitCnt  <= '0;
            rxDone  <= 1'b0;
        end else begin
            rxDone <= 1'b0;
            if (rxEnable) begin
                enLatch <= 1'b1;
            end
            if (take) begin
                if (bitCnt == 2*dataWidth - 1) begin
                    bitCnt  <= '0;
                    enLatch <= 1'b0;
                    rxDone  <= 1'b1;   // all sixteen bits in
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end
        end
    end

    // msb first, ack byte ends up in the upper half
    always_ff @(posedge clk) begin
        if (take) begin
            frame <= {frame.ackByte[dataWidth-2:0], frame.payload, rD};
        end
    end

    assign ackOk   = (frame.ackByte == ackValue);
    assign payload = frame.payload;

endmodule

// ==== source/frameTransmitter.sv ====
module frameTransmitter
    import masterPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  xferReqT req,
    input  logic    grant,
    input  logic    releaseCtl,
    output slaveTxT slaveTx,
    output logic    rxEnable,
    output logic    frameDone
);

    xferOpE             opLatch;
    dataT               dataLatch;
    dataT               dataShift;
    logic [ctrlLen-1:0] ctrlFrame;
    logic [ctrlLen-1:0] ctrlShift;
    logic [3:0]         bitCnt;     // bits already on the line
    logic               ctrlBusy;
    logic               dataBusy;
    logic               ctrlBit;
    logic               wrBit;
    logic               validBit;

    assign ctrlFrame = {framePrefix, slaveId, opLatch};

    // request kept until the arbiter grants the bus
    always_ff @(posedge clk) begin
        if (req.go) begin
            opLatch   <= req.op;
            dataLatch <= req.wrData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlBusy  <= 1'b0;
            dataBusy  <= 1'b0;
            bitCnt    <= '0;
            ctrlBit   <= 1'b0;
            wrBit     <= 1'b0;
            validBit  <= 1'b0;
            rxEnable  <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            rxEnable  <= 1'b0;
            frameDone <= 1'b0;
            if (grant) begin
                ctrlBit   <= ctrlFrame[ctrlLen-1];
                ctrlShift <= ctrlFrame << 1;
                bitCnt    <= 4'd1;
                ctrlBusy  <= 1'b1;
            end else if (ctrlBusy) begin
                if (bitCnt < ctrlLen) begin
                    ctrlBit   <= ctrlShift[ctrlLen-1];
                    ctrlShift <= ctrlShift << 1;
                    bitCnt    <= bitCnt + 1'b1;
                end else begin
                    ctrlBit  <= 1'b0;
                    ctrlBusy <= 1'b0;
                    if (opLatch == opWrite) begin
                        // data follows the frame with no gap
                        wrBit     <= dataLatch[dataWidth-1];
                        dataShift <= dataLatch << 1;
                        validBit  <= 1'b1;
                        bitCnt    <= 4'd1;
                        dataBusy  <= 1'b1;
                    end else begin
                        rxEnable <= 1'b1;   // hand over to the receiver
                    end
                end
            end else if (dataBusy) begin
                if (bitCnt < dataWidth) begin
                    wrBit     <= dataShift[dataWidth-1];
                    dataShift <= dataShift << 1;
                    bitCnt    <= bitCnt + 1'b1;
                end else begin
                    wrBit     <= 1'b0;
                    validBit  <= 1'b0;
                    dataBusy  <= 1'b0;
                    frameDone <= 1'b1;
                end
            end
        end
    end

    // release pulse shares the control line
    assign slaveTx = '{control: ctrlBit | releaseCtl, wrD: wrBit, valid: validBit};

endmodule

// ==== source/masterExternal.sv ====
module masterExternal
    import masterPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     start,
    input  logic     eoc,
    input  logic     rD,
    input  logic     ready,
    input  logic     arbCont,
    output doneCodeE doneCom,
    output dataT     dataOut,
    output logic     disData,
    output logic     control,
    output logic     wrD,
    output logic     valid,
    output logic     arbSend
);

    xferReqT req;
    slaveTxT slaveTx;
    dataT    payload;
    logic    grant;
    logic    busFree;
    logic    releaseCtl;
    logic    rxEnable;
    logic    frameDone;
    logic    rxDone;
    logic    ackOk;
    logic    xferEnd;     // write or read finished

    assign xferEnd = frameDone | rxDone;

    masterSequencer sequencer (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .eoc     (eoc),
        .busFree (busFree),
        .rxDone  (rxDone),
        .ackOk   (ackOk),
        .payload (payload),
        .req     (req),
        .dataOut (dataOut),
        .disData (disData),
        .doneCom (doneCom)
    );

    arbRequester requester (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .arbCont    (arbCont),
        .releaseBus (xferEnd),
        .arbSend    (arbSend),
        .grant      (grant),
        .busFree    (busFree),
        .releaseCtl (releaseCtl)
    );

    frameTransmitter transmitter (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .grant      (grant),
        .releaseCtl (releaseCtl),
        .slaveTx    (slaveTx),
        .rxEnable   (rxEnable),
        .frameDone  (frameDone)
    );

    frameReceiver receiver (
        .clk      (clk),
        .rstN     (rstN),
        .rxEnable (rxEnable),
        .rD       (rD),
        .ready    (ready),
        .rxDone   (rxDone),
        .ackOk    (ackOk),
        .payload  (payload)
    );

    assign control = slaveTx.control;
    assign wrD     = slaveTx.wrD;
    assign valid   = slaveTx.valid;

endmodule

// ==== source/masterPkg.sv ====
package masterPkg;

    //////////////////////////////////////////////////////////////////////
    // link constants
    //////////////////////////////////////////////////////////////////////
    localparam int dataWidth     = 8;
    localparam int ctrlLen       = 7;     // prefix, slave id, r/w bit
    localparam int arbReqLen     = 6;     // prefix then slave id
    localparam int displayCycles = 5;     // cycles of disData high
    localparam int grantWait     = 4;     // quiet cycles before grant

    localparam logic [2:0] framePrefix = 3'b111;
    localparam logic [2:0] slaveId     = 3'b101;

    typedef logic [dataWidth-1:0] dataT;

    localparam dataT ackValue  = 8'hCC;   // expected first read byte
    localparam dataT startData = 8'h0A;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // also the last bit of the control frame
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } xferOpE;

    typedef enum logic [1:0] {
        doneNone = 2'd0,
        doneFail = 2'd1,
        doneOk   = 2'd3
    } doneCodeE;

    typedef enum logic [2:0] {
        configMaster,
        idle,
        displayData,
        writeData,
        readData,
        endCom
    } topStateE;

    typedef enum logic [2:0] {
        arbIdle,
        arbShift,
        arbWaitGrant,
        arbAck,
        arbOwn,
        arbRelease
    } arbStateE;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        dataT ackByte;   // arrives first
        dataT payload;
    } readFrameT;

    typedef struct packed {
        logic control;
        logic wrD;
        logic valid;
    } slaveTxT;

    typedef struct packed {
        logic   go;      // one cycle, starts a transaction
        xferOpE op;
        dataT   wrData;
    } xferReqT;

endpackage

// ==== source/masterSequencer.sv ====
module masterSequencer
    import masterPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     start,
    input  logic     eoc,
    input  logic     busFree,
    input  logic     rxDone,
    input  logic     ackOk,
    input  dataT     payload,
    output xferReqT  req,
    output dataT     dataOut,
    output logic     disData,
    output doneCodeE doneCom
);

    topStateE                         state;
    dataT                             dataReg;   // value shown and written
    logic [$clog2(displayCycles)-1:0] dispCnt;

    assign dataOut = dataReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= configMaster;
            dataReg <= '0;
            dispCnt <= '0;
            disData <= 1'b0;
            doneCom <= doneNone;
            req     <= '{go: 1'b0, op: opRead, wrData: '0};
        end else begin
            req.go <= 1'b0;
            case (state)
                configMaster: begin
                    if (start) begin
                        state <= idle;
                    end
                end

                idle: begin
                    if (eoc) begin
                        doneCom <= doneFail;
                        state   <= endCom;
                    end else if (start) begin
                        dataReg <= startData;
                        dispCnt <= '0;
                        disData <= 1'b1;
                        state   <= displayData;
                    end else begin
                        // nothing to show, listen to the other board
                        req   <= '{go: 1'b1, op: opRead, wrData: dataReg};
                        state <= readData;
                    end
                end

                //////////////////////////////////////////////////////////////////////
                // display, then write the next value
                //////////////////////////////////////////////////////////////////////
                displayData: begin
                    if (dispCnt == displayCycles - 1) begin
                        disData <= 1'b0;
                        dataReg <= dataReg + 1'b1;
                        req     <= '{go: 1'b1, op: opWrite, wrData: dataT'(dataReg + 1'b1)};
                        state   <= writeData;
                    end else begin
                        dispCnt <= dispCnt + 1'b1;
                    end
                end

                writeData: begin
                    if (eoc) begin
                        doneCom <= doneFail;
                        state   <= endCom;
                    end else if (busFree) begin
                        // write is out, ask for the answer
                        req   <= '{go: 1'b1, op: opRead, wrData: dataReg};
                        state <= readData;
                    end
                end

                //////////////////////////////////////////////////////////////////////
                // read back and check the ack byte
                //////////////////////////////////////////////////////////////////////
                readData: begin
                    if (eoc) begin
                        doneCom <= doneFail;
                        state   <= endCom;
                    end else if (rxDone) begin
                        if (ackOk) begin
                            dataReg <= payload;
                            doneCom <= doneOk;
                            dispCnt <= '0;
                            disData <= 1'b1;
                            state   <= displayData;
                        end else begin
                            doneCom <= doneFail;   // bad ack ends the link
                            state   <= endCom;
                        end
                    end
                end

                endCom: begin
                    disData <= 1'b0;   // held here until reset
                end

                default: state <= configMaster;
            endcase
        end
    end

endmodule

// ==== verification/masterExternal_chk.sv ====
module masterExternal_chk
    import masterPkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     control,
    input logic     valid,
    input logic     arbSend,
    input logic     disData,
    input doneCodeE doneCom
);

    int failCount = 0;   // assertion failures so far

    // write data only once the frame is out
    validCtrl: assert property (@(posedge clk) disable iff (!rstN) valid |-> !control)
        else begin
            failCount++;
            $error("valid high while control is high");
        end

    validArb: assert property (@(posedge clk) disable iff (!rstN) valid |-> !arbSend)
        else begin
            failCount++;
            $error("valid high while arbSend is high");
        end

    resetQuiet: assert property (@(posedge clk)
        $rose(rstN) |-> !arbSend && !control && !valid && !disData)
        else begin
            failCount++;
            $error("outputs not low after reset");
        end

    // a failure code is final until reset
    doneCodes: assert property (@(posedge clk) disable iff (!rstN)
        doneCom != $past(doneCom) |->
            doneCom inside {doneOk, doneFail} && $past(doneCom) != doneFail)
        else begin
            failCount++;
            $error("doneCom left doneFail or took an unknown code");
        end

endmodule

bind masterExternal masterExternal_chk chk (
    .clk     (clk),
    .rstN    (rstN),
    .control (control),
    .valid   (valid),
    .arbSend (arbSend),
    .disData (disData),
    .doneCom (doneCom)
);

// ==== verification/masterTb.sv ====
module masterTb
    import masterPkg::*;
();

    localparam int maxRecords  = 16;
    localparam int bitsPerRead = 2 * dataWidth;
    localparam int startCost   = 40;    // reset, start and first display
    localparam int recordCost  = 130;   // write, read and display without waits
    localparam int eocCost     = 60;
    localparam int quietCycles = 12;

    logic     clk;
    logic     rstN;
    logic     resetReq;
    logic     start;
    logic     eoc;
    logic     rD;
    logic     ready;
    logic     arbCont;
    doneCodeE doneCom;
    dataT     dataOut;
    logic     disData;
    logic     control;
    logic     wrD;
    logic     valid;
    logic     arbSend;

    dataT        traceMem [0:4*maxRecords-1];   // four bytes per record
    int          readyGap [0:bitsPerRead*maxRecords-1];
    int          numRecords = 0;
    int          cycleLimit = 0;
    int          cycles     = 0;
    int          errors     = 0;
    int          checks     = 0;
    int          tests      = 0;
    int unsigned lcgState   = 94942;

    tbClock clkGen (.resetReq(resetReq), .clk(clk), .rstN(rstN));

    masterExternal uut (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .eoc     (eoc),
        .rD      (rD),
        .ready   (ready),
        .arbCont (arbCont),
        .doneCom (doneCom),
        .dataOut (dataOut),
        .disData (disData),
        .control (control),
        .wrD     (wrD),
        .valid   (valid),
        .arbSend (arbSend)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout: the DUT made no progress within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    task automatic step();
        @(posedge clk);
    endtask

    task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic endTest(input string name, input int errBefore);
        tests++;
        if (errors == errBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errBefore);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // arbiter and slave side
    //////////////////////////////////////////////////////////////////////
    task automatic captureRequest();
        logic [arbReqLen-1:0] bits;
        int                   i;
        do step(); while (arbSend !== 1'b1);   // request opens with a one
        bits[arbReqLen-1] = arbSend;
        for (i = arbReqLen - 2; i >= 0; i--) begin
            step();
            bits[i] = arbSend;
        end
        compareValue("arbSend request", bits, {framePrefix, slaveId});
    endtask

    task automatic grantBus(input int delay);
        logic [2:0] ackBits;
        repeat (delay) step();
        arbCont <= 1'b1;
        do step(); while (arbSend !== 1'b1);
        arbCont    <= 1'b0;   // free again for the next request
        ackBits[2] = arbSend;
        step();
        ackBits[1] = arbSend;
        step();
        ackBits[0] = arbSend;
        compareValue("arbSend ack", ackBits, 3'b101);
    endtask

    task automatic readCtrlFrame(input xferOpE op);
        logic [ctrlLen-1:0] bits;
        int                 i;
        do step(); while (control !== 1'b1);
        bits[ctrlLen-1] = control;
        for (i = ctrlLen - 2; i >= 0; i--) begin
            step();
            bits[i] = control;
        end
        compareValue("control frame", bits, {framePrefix, slaveId, op});
    endtask

    task automatic sampleWriteData(input dataT exp);
        dataT bits;
        int   i;
        for (i = dataWidth - 1; i >= 0; i--) begin
            step();
            compareValue("valid", valid, 1'b1);
            bits[i] = wrD;
        end
        step();
        compareValue("valid after data", valid, 1'b0);
        compareValue("wrD", bits, exp);
    endtask

    // slave answer msb first with ready gaps
    task automatic sendReadWord(input logic [bitsPerRead-1:0] word, input int gapBase);
        int i;
        int g;
        for (i = bitsPerRead - 1; i >= 0; i--) begin
            for (g = 0; g < readyGap[gapBase + i]; g++) begin
                ready <= 1'b0;
                step();
            end
            ready <= 1'b1;
            rD    <= word[i];
            step();
        end
        ready <= 1'b0;
        rD    <= 1'b0;
    endtask

    task automatic watchRelease();
        do step(); while (control !== 1'b1);
        compareValue("arbSend at release", arbSend, 1'b0);
        step();
        compareValue("arbSend release", arbSend, 1'b1);
        step();
        compareValue("arbSend release", arbSend, 1'b1);
        step();
        compareValue("arbSend after release", arbSend, 1'b0);
        compareValue("control after release", control, 1'b0);
    endtask

    task automatic measureDisplay(
        input dataT     expData,
        input doneCodeE expDone,
        input dataT     nextExp
    );
        int highCycles;
        highCycles = 0;
        do step(); while (disData !== 1'b1);
        while (disData === 1'b1) begin
            highCycles++;
            compareValue("dataOut", dataOut, expData);
            compareValue("doneCom", doneCom, expDone);
            step();
        end
        compareValue("disData cycles", highCycles, displayCycles);
        compareValue("dataOut after display", dataOut, nextExp);   // incremented value
    endtask

    task automatic expectQuiet(input doneCodeE expDone);
        int i;
        for (i = 0; i < quietCycles; i++) begin
            step();
            compareValue("arbSend", arbSend, 1'b0);
            compareValue("control", control, 1'b0);
            compareValue("valid", valid, 1'b0);
            compareValue("disData", disData, 1'b0);
        end
        compareValue("doneCom", doneCom, expDone);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int       rec;
        int       i;
        int       errBefore;
        int       delay;
        dataT     ack;
        dataT     pay;
        dataT     next;
        dataT     expWrite;
        logic     linkOpen;

        resetReq = 1'b0;
        start    = 1'b0;
        eoc      = 1'b0;
        rD       = 1'b0;
        ready    = 1'b0;
        arbCont  = 1'b0;

        $readmemh("verification/masterTrace.txt", traceMem);
        while (numRecords < maxRecords && !$isunknown(traceMem[4*numRecords])) begin
            numRecords++;
        end
        for (i = 0; i < bitsPerRead * maxRecords; i++) begin
            readyGap[i] = (nextRandom() >> 16) % 4;
        end
        // budget from grant delays and ready gaps plus a fixed cost
        cycleLimit = startCost + eocCost;
        for (rec = 0; rec < numRecords; rec++) begin
            cycleLimit += recordCost + 2 * int'(traceMem[4*rec+2]);
            for (i = 0; i < bitsPerRead; i++) begin
                cycleLimit += readyGap[rec*bitsPerRead + i];
            end
        end

        do step(); while (rstN !== 1'b1);
        errBefore = errors;
        start <= 1'b1;
        step();
        step();
        start <= 1'b0;   // idle has seen start by now
        expWrite = dataT'(startData + 1);
        measureDisplay(startData, doneNone, expWrite);
        endTest("start display", errBefore);

        linkOpen = 1'b1;
        for (rec = 0; rec < numRecords && linkOpen; rec++) begin
            ack   = traceMem[4*rec];
            pay   = traceMem[4*rec+1];
            delay = traceMem[4*rec+2];
            next  = traceMem[4*rec+3];

            errBefore = errors;
            captureRequest();
            grantBus(delay);
            readCtrlFrame(opWrite);
            sampleWriteData(expWrite);
            watchRelease();
            endTest($sformatf("record %0d write", rec), errBefore);

            errBefore = errors;
            captureRequest();
            grantBus(delay);
            readCtrlFrame(opRead);
            sendReadWord({ack, pay}, rec * bitsPerRead);
            if (ack == ackValue) begin
                fork
                    watchRelease();
                    measureDisplay(pay, doneOk, next);
                join
                expWrite = next;
            end else begin
                watchRelease();
                expectQuiet(doneFail);
                compareValue("dataOut after bad ack", dataOut, next);
                linkOpen = 1'b0;   // link is closed until reset
            end
            endTest($sformatf("record %0d read", rec), errBefore);
        end

        // second run with eoc while the arbiter holds back the grant
        errBefore = errors;
        resetReq <= 1'b1;
        step();
        resetReq <= 1'b0;
        do step(); while (rstN !== 1'b0);
        do step(); while (rstN !== 1'b1);
        start <= 1'b1;
        step();
        start <= 1'b0;   // short start so idle goes to a read
        captureRequest();
        eoc <= 1'b1;
        expectQuiet(doneFail);
        eoc <= 1'b0;
        endTest("eoc during grant wait", errBefore);

        errors += uut.chk.failCount;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verification/masterTrace.txt ====
// one read transaction per line, all hex:
// ack byte, payload byte, grant delay in cycles, expected dataOut afterwards
// a bad ack closes the link, so it is the last record
CC 3C 02 3D
CC FF 05 00
CC 80 00 81
CC 01 07 02
35 5E 03 02

// ==== verification/tbClock.sv ====
module tbClock (
    input  logic resetReq,   // opens a new reset window
    output logic clk,
    output logic rstN
);

    localparam int period      = 40;
    localparam int resetCycles = 4;

    int rstCnt = 0;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (resetReq) begin
            rstCnt <= 0;
        end else if (rstCnt < resetCycles) begin
            rstCnt <= rstCnt + 1;
        end
    end

    assign rstN = (rstCnt >= resetCycles);

endmodule

// ==== vlog.f ====
source/masterPkg.sv
source/arbRequester.sv
source/frameTransmitter.sv
source/frameReceiver.sv
source/masterSequencer.sv
source/masterExternal.sv
verification/tbClock.sv
verification/masterExternal_chk.sv
verification/masterTb.sv
